// ==== design/song.mem ====
// one note number per line in hex, 00 is a rest
// each step takes two lines, the lead note first and then the bass note
31 // step 0
19
35
19
38
1e
35
1e
31
1a
2c
1a
2f
1c
00 // step 7, lead rests
1c
2d
20
31
20
34
21
31
21
2f
1e
2d
1e
2c
19
00 // step 15, both voices rest
00
31
19
33
19
35
1c
36
1c
38
1e
36
1e
35
1a
33 // step 23, bass rests
00
31
19
31
19
2f
1c
2d
1c
2c
1e
2f
1e
31
19
00 // step 31, both rest before the loop
00

// ==== build.f ====
design/music_pkg.sv
design/note_rom.sv
design/note_sequencer.sv
design/wave_gen.sv
design/dac_sampler.sv
design/music_player.sv
verif/music_player_assert.sv
verif/music_player_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the music player testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module music_player_tb -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# note_rom loads song.mem from the working directory
cp design/song.mem song.mem
if [ $? -ne 0 ]; then
    echo "could not copy design/song.mem"
    exit 1
fi

sim_output=$(./obj_dir/Vmusic_player_tb)
sim_status=$?
rm -f song.mem
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Test OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verif/music_player_tb.sv ====
`timescale 1ns/1ps

module music_player_tb;

    localparam int SAMPLE_DIV   = 8;
    localparam int STEP_SAMPLES = 64;
    localparam int STEP_CYCLES  = SAMPLE_DIV * STEP_SAMPLES;

    // one square-wave voice as the model tracks it
    typedef struct packed {
        music_pkg::note_t          note;
        music_pkg::half_period_t   count;
        logic                      phase;
    } voice_state_t;

    logic               clk;
    logic               reset;
    logic               play;
    music_pkg::sample_t dac;

    music_pkg::note_t   song [0:2*music_pkg::SONG_LEN-1];
    voice_state_t       lead_model;
    voice_state_t       bass_model;
    music_pkg::step_t   model_step;
    int                 model_step_count;
    int                 model_div;
    music_pkg::sample_t model_dac;
    int                 sample_rests; // rests among the two voices at the last tick
    bit                 tick_pending;
    bit                 fresh_sample;

    music_pkg::sample_t step0_samples [$];
    music_pkg::sample_t captured [$];

    int unsigned        lcg_state;
    string              test_name;
    int                 dac_errors;
    int                 step_errors;
    int                 other_errors;

    music_player #(
        .SAMPLE_DIV   (SAMPLE_DIV),
        .STEP_SAMPLES (STEP_SAMPLES)
    ) music_player_i (
        .clk   (clk),
        .reset (reset),
        .play  (play),
        .dac   (dac)
    );

    always #10 clk = ~clk;

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic check_dac(input music_pkg::sample_t expected, input music_pkg::sample_t actual);
        if (actual !== expected) begin
            dac_errors++;
            $display("Mismatch %s dac expected %0d actual %0d", test_name, expected, actual);
        end
    endtask

    task automatic check_step(input music_pkg::step_t expected, input music_pkg::step_t actual);
        if (actual !== expected) begin
            step_errors++;
            $display("Mismatch %s step expected %0d actual %0d", test_name, expected, actual);
        end
    endtask

    function automatic voice_state_t restart_voice(voice_state_t s, music_pkg::note_t raw);
        voice_state_t next;
        next = s;
        // a note that carries into the next step keeps its wave running
        if (raw[5:0] != s.note[5:0]) begin
            next.note  = {2'b00, raw[5:0]};
            next.count = '0;
            next.phase = 1'b0;
        end
        return next;
    endfunction

    function automatic voice_state_t advance_voice(voice_state_t s);
        voice_state_t            next;
        music_pkg::half_period_t half;
        next = s;
        half = music_pkg::HALF_PERIOD_TABLE[s.note[5:0]];
        if (s.note[5:0] != 6'd0) begin
            if (s.count + 1'b1 == half) begin
                next.count = '0;
                next.phase = ~s.phase;
            end else begin
                next.count = s.count + 1'b1;
            end
        end
        return next;
    endfunction

    function automatic music_pkg::sample_t voice_level(voice_state_t s);
        return s.phase ? music_pkg::VOICE_LEVEL : '0;
    endfunction

    task automatic load_step_notes();
        lead_model = restart_voice(lead_model, song[{model_step, 1'b0}]);
        bass_model = restart_voice(bass_model, song[{model_step, 1'b1}]);
    endtask

    task automatic model_reset();
        model_step       = '0;
        model_step_count = 0;
        model_div        = 0;
        model_dac        = '0;
        tick_pending     = 1'b0;
        lead_model       = '0;
        bass_model       = '0;
        load_step_notes();
    endtask

    // dac takes the levels as they stand at the tick, then both voices move on
    task automatic model_tick();
        model_dac    = voice_level(lead_model) + voice_level(bass_model);
        sample_rests = int'(lead_model.note == '0) + int'(bass_model.note == '0);
        lead_model   = advance_voice(lead_model);
        bass_model   = advance_voice(bass_model);
        if (model_step_count == STEP_SAMPLES - 1) begin
            model_step_count = 0;
            if (model_step == music_pkg::step_t'(music_pkg::SONG_LEN - 1)) begin
                model_step = '0;
            end else begin
                model_step = model_step + 1'b1;
            end
            load_step_notes();
        end else begin
            model_step_count++;
        end
    endtask

    // checks what the last rising edge produced, then drives the next cycle
    task automatic run_cycle(input logic reset_value, input logic play_value);
        @(negedge clk);
        check_dac(model_dac, dac);
        check_step(model_step, music_player_i.step_index);
        fresh_sample = tick_pending;
        reset        = reset_value;
        play         = play_value;
        tick_pending = 1'b0;
        if (reset_value) begin
            model_reset();
        end else if (play_value) begin
            if (model_div == SAMPLE_DIV - 1) begin
                model_div    = 0;
                tick_pending = 1'b1;
                model_tick();
            end else begin
                model_div++;
            end
        end
    endtask

    task automatic apply_reset();
        for (int i = 0; i < 8; i++) begin
            run_cycle(1'b1, 1'b0);
        end
        run_cycle(1'b0, 1'b0);
    endtask

    task automatic check_rest_levels();
        if (sample_rests == 2) begin
            check_dac('0, dac);
        end else if (sample_rests == 1 && dac !== '0 && dac !== music_pkg::VOICE_LEVEL) begin
            dac_errors++;
            $display("Mismatch %s dac expected 0 or %0d actual %0d", test_name,
                     music_pkg::VOICE_LEVEL, dac);
        end
    endtask

    task automatic play_until_step(input music_pkg::step_t target, input bit record,
                                   input bit check_rests, input int limit);
        int cycles;
        cycles = 0;
        captured.delete();
        while (music_player_i.step_index != target && cycles < limit) begin
            run_cycle(1'b0, 1'b1);
            cycles++;
            if (fresh_sample && record) begin
                captured.push_back(dac);
            end
            if (fresh_sample && check_rests) begin
                check_rest_levels();
            end
        end
        if (music_player_i.step_index != target) begin
            other_errors++;
            $display("%s timed out after %0d cycles waiting for step %0d", test_name,
                     limit, target);
        end
    endtask

    task automatic compare_with_step0();
        if (captured.size() != step0_samples.size()) begin
            other_errors++;
            $display("%s captured %0d samples of step 0 but the first pass had %0d",
                     test_name, captured.size(), step0_samples.size());
        end else begin
            foreach (captured[i]) begin
                check_dac(step0_samples[i], captured[i]);
            end
        end
    endtask

    task automatic test_reset_idle();
        test_name = "reset_idle";
        apply_reset();
        for (int i = 0; i < 5; i++) begin
            run_cycle(1'b0, 1'b0);
        end
        // play rises here and the first tick is still SAMPLE_DIV cycles away
        for (int i = 0; i < SAMPLE_DIV - 1; i++) begin
            run_cycle(1'b0, 1'b1);
        end
    endtask

    task automatic test_first_step();
        test_name = "first_step";
        play_until_step(5'd1, 1'b1, 1'b0, 2 * STEP_CYCLES);
        step0_samples = captured;
        if (step0_samples.size() != STEP_SAMPLES) begin
            other_errors++;
            $display("%s saw %0d samples in step 0 instead of %0d", test_name,
                     step0_samples.size(), STEP_SAMPLES);
        end
    endtask

    task automatic test_rest_steps();
        test_name = "rest_steps";
        play_until_step(5'd0, 1'b0, 1'b1, music_pkg::SONG_LEN * STEP_CYCLES);
    endtask

    task automatic test_wrap();
        test_name = "song_wrap";
        play_until_step(5'd1, 1'b1, 1'b0, 2 * STEP_CYCLES);
        compare_with_step0();
    endtask

    task automatic test_pause();
        int                 run_len;
        int                 hold_len;
        music_pkg::sample_t held;
        test_name = "pause";
        for (int round = 0; round < 6; round++) begin
            run_len  = int'(next_random() % 300) + 1;
            hold_len = int'(next_random() % 60) + 1;
            for (int i = 0; i < run_len; i++) begin
                run_cycle(1'b0, 1'b1);
            end
            run_cycle(1'b0, 1'b0);
            held = model_dac;
            for (int i = 0; i < hold_len; i++) begin
                run_cycle(1'b0, 1'b0);
                check_dac(held, dac);
            end
        end
    endtask

    task automatic test_mid_reset();
        music_pkg::step_t target;
        test_name = "mid_reset";
        target    = model_step + 5'd2;
        play_until_step(target, 1'b0, 1'b0, 3 * STEP_CYCLES);
        for (int i = 0; i < 100; i++) begin
            run_cycle(1'b0, 1'b1);
        end
        apply_reset();
        check_dac('0, dac);
        check_step('0, music_player_i.step_index);
        play_until_step(5'd1, 1'b1, 1'b0, 2 * STEP_CYCLES);
        compare_with_step0();
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        play         = 1'b0;
        lcg_state    = 32'd70734;
        fresh_sample = 1'b0;
        sample_rests = 0;
        dac_errors   = 0;
        step_errors  = 0;
        other_errors = 0;
        test_name    = "setup";
        $readmemh("design/song.mem", song);
        if ($isunknown(song[0]) || $isunknown(song[2*music_pkg::SONG_LEN-1])) begin
            other_errors++;
            $display("song data from design/song.mem did not load completely");
        end
        model_reset();

        test_reset_idle();
        test_first_step();
        test_rest_steps();
        test_wrap();
        test_pause();
        test_mid_reset();

        $display("dac errors %0d, step errors %0d, other errors %0d", dac_errors,
                 step_errors, other_errors);
        if (dac_errors + step_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/music_player_assert.sv ====
`timescale 1ns/1ps

module music_player_assert (
    input logic               clk,
    input logic               reset,
    input logic               play,
    input logic               sample_tick,
    input music_pkg::step_t   step_index,
    input music_pkg::sample_t dac
);

    // the sampler loads only on a tick, so dac stays flat unless a tick or reset came first
    dac_only_after_tick: assert property (
        @(posedge clk) disable iff (reset)
        (!$past(sample_tick) && !$past(reset)) |-> $stable(dac)
    ) else $error("dac changed without a sample tick in the cycle before");

    // a paused player leaves both the step and the ladder pins where they were
    no_tick_while_paused: assert property (
        @(posedge clk) disable iff (reset)
        !play |=> ($stable(step_index) && $stable(dac))
    ) else $error("step_index or dac moved while play was low");

    // the wrap from the last step to 0 is the natural overflow of step_t
    step_moves_by_one: assert property (
        @(posedge clk) disable iff (reset)
        (step_index != $past(step_index)) |->
            (step_index == music_pkg::step_t'($past(step_index) + 1'b1))
    ) else $error("step_index jumped by more than one step");

endmodule

bind music_player music_player_assert assert_i (
    .clk         (clk),
    .reset       (reset),
    .play        (play),
    .sample_tick (sample_tick),
    .step_index  (step_index),
    .dac         (dac)
);

// ==== design/music_player.sv ====
`timescale 1ns/1ps

module music_player #(
    parameter int SAMPLE_DIV   = music_pkg::DEFAULT_SAMPLE_DIV,
    parameter int STEP_SAMPLES = music_pkg::DEFAULT_STEP_SAMPLES
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                play,
    output music_pkg::sample_t  dac
);
    logic                sample_tick;
    music_pkg::step_t    step_index;
    music_pkg::note_t    lead_note;
    music_pkg::note_t    bass_note;
    music_pkg::sample_t  lead_level;
    music_pkg::sample_t  bass_level;

    note_sequencer #(
        .SAMPLE_DIV   (SAMPLE_DIV),
        .STEP_SAMPLES (STEP_SAMPLES)
    ) sequencer (
        .clk         (clk),
        .reset       (reset),
        .play        (play),
        .sample_tick (sample_tick),
        .step_index  (step_index)
    );

    note_rom song_rom (
        .clk        (clk),
        .step_index (step_index),
        .lead_note  (lead_note),
        .bass_note  (bass_note)
    );

    wave_gen lead_voice (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .note        (lead_note),
        .level       (lead_level)
    );

    wave_gen bass_voice (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .note        (bass_note),
        .level       (bass_level)
    );

    dac_sampler sampler (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .lead_level  (lead_level),
        .bass_level  (bass_level),
        .dac         (dac)
    );

endmodule

// ==== design/dac_sampler.sv ====
`timescale 1ns/1ps

module dac_sampler (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_tick,
    input  music_pkg::sample_t  lead_level,
    input  music_pkg::sample_t  bass_level,
    output music_pkg::sample_t  dac
);
    music_pkg::sample_t mix;

    assign mix = lead_level + bass_level; // cannot wrap with two voices at VOICE_LEVEL

    // the ladder pins only move at the audio rate, which keeps the output free of
    // glitches from the voices updating mid-sample
    always_ff @(posedge clk) begin
        if (reset) begin
            dac <= '0;
        end else if (sample_tick) begin
            dac <= mix;
        end
    end

endmodule

// ==== design/wave_gen.sv ====
`timescale 1ns/1ps

module wave_gen (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_tick,
    input  music_pkg::note_t    note,
    output music_pkg::sample_t  level
);
    music_pkg::note_t          last_note;
    music_pkg::half_period_t   count;
    music_pkg::half_period_t   half_period;
    music_pkg::half_period_t   count_next;
    logic                      phase;
    logic                      note_change;
    logic                      rest;

    // only the low six bits select a note
    assign note_change = note[5:0] != last_note[5:0];
    assign half_period = music_pkg::HALF_PERIOD_TABLE[last_note[5:0]];
    assign rest        = last_note[5:0] == 6'd0;
    assign count_next  = count + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_note <= '0;
            count     <= '0;
            phase     <= 1'b0;
        end else if (note_change) begin
            // a new note always starts low with a fresh count
            last_note <= note;
            count     <= '0;
            phase     <= 1'b0;
        end else if (sample_tick && !rest) begin
            if (count_next == half_period) begin
                count <= '0;
                phase <= ~phase;
            end else begin
                count <= count_next;
            end
        end
    end

    // phase never leaves 0 during a rest, since the counter is held
    assign level = phase ? music_pkg::VOICE_LEVEL : '0;

endmodule

// ==== design/note_sequencer.sv ====
`timescale 1ns/1ps

module note_sequencer #(
    parameter int SAMPLE_DIV   = music_pkg::DEFAULT_SAMPLE_DIV,
    parameter int STEP_SAMPLES = music_pkg::DEFAULT_STEP_SAMPLES
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                play,
    output logic                sample_tick,
    output music_pkg::step_t    step_index
);
    localparam int DIV_W  = $clog2(SAMPLE_DIV + 1);
    localparam int STEP_W = $clog2(STEP_SAMPLES + 1);

    logic [DIV_W-1:0]  div_count;
    logic [STEP_W-1:0] step_count;
    logic              step_done;

    // the tick is combinational so it drops in the same cycle that play falls
    assign sample_tick = play && (div_count == DIV_W'(SAMPLE_DIV - 1));
    assign step_done   = step_count == STEP_W'(STEP_SAMPLES - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            div_count <= '0;
        end else if (play) begin
            if (sample_tick) begin
                div_count <= '0;
            end else begin
                div_count <= div_count + 1'b1;
            end
        end
    end

    // step counter and step index only move on ticks, so pausing freezes them too
    always_ff @(posedge clk) begin
        if (reset) begin
            step_count <= '0;
            step_index <= '0;
        end else if (sample_tick) begin
            if (step_done) begin
                step_count <= '0;
                if (step_index == music_pkg::step_t'(music_pkg::SONG_LEN - 1)) begin
                    step_index <= '0; // song loops forever
                end else begin
                    step_index <= step_index + 1'b1;
                end
            end else begin
                step_count <= step_count + 1'b1;
            end
        end
    end

endmodule

// ==== design/note_rom.sv ====
`timescale 1ns/1ps

module note_rom (
    input  logic                clk,
    input  music_pkg::step_t    step_index,
    output music_pkg::note_t    lead_note,
    output music_pkg::note_t    bass_note
);
    localparam int ADDR_W = $clog2(2 * music_pkg::SONG_LEN);

    // each step takes two bytes, lead first and bass second
    music_pkg::note_t song_mem [0:2*music_pkg::SONG_LEN-1];

    logic [ADDR_W-1:0] lead_addr;
    logic [ADDR_W-1:0] bass_addr;

    initial begin
        $readmemh("song.mem", song_mem);
    end

    assign lead_addr = {step_index, 1'b0};
    assign bass_addr = {step_index, 1'b1};

    always_ff @(posedge clk) begin
        lead_note <= song_mem[lead_addr];
        bass_note <= song_mem[bass_addr];
    end

endmodule

// ==== design/music_pkg.sv ====
package music_pkg;

    // note 0 is a rest, 1 to 63 climb in semitones from A2
    typedef logic [7:0] note_t;
    typedef logic [4:0] step_t;
    typedef logic [7:0] sample_t;
    typedef logic [7:0] half_period_t;

    // two voices at this level sum to 254 and never wrap the DAC code
    localparam sample_t VOICE_LEVEL = 8'd127;

    localparam int SONG_LEN = 32;

    // 50 MHz clock, 50 kHz audio rate
    localparam int DEFAULT_SAMPLE_DIV = 1000;
    // 12500 samples per step gives four steps per second
    localparam int DEFAULT_STEP_SAMPLES = 12500;

    // half period in sample ticks, round(50000 / (2 * f)) with note 1 at 110 Hz
    localparam half_period_t HALF_PERIOD_TABLE [0:63] = '{
        8'd0,   // rest
        // octave 1
        8'd227, 8'd215, 8'd202, 8'd191,
        8'd180, 8'd170, 8'd161, 8'd152,
        8'd143, 8'd135, 8'd128, 8'd120,
        // octave 2
        8'd114, 8'd107, 8'd101, 8'd96,
        8'd90,  8'd85,  8'd80,  8'd76,
        8'd72,  8'd68,  8'd64,  8'd60,
        // octave 3
        8'd57,  8'd54,  8'd51,  8'd48,
        8'd45,  8'd43,  8'd40,  8'd38,
        8'd36,  8'd34,  8'd32,  8'd30,
        // octave 4
        8'd28,  8'd27,  8'd25,  8'd24,
        8'd23,  8'd21,  8'd20,  8'd19,
        8'd18,  8'd17,  8'd16,  8'd15,
        // octave 5
        8'd14,  8'd13,  8'd13,  8'd12,
        8'd11,  8'd11,  8'd10,  8'd9,
        8'd9,   8'd8,   8'd8,   8'd8,
        // top of the range, pitch steps get coarse here
        8'd7,   8'd7,   8'd6
    };

endpackage
